//--- bossMotionPkg.sv
package bossMotionPkg;

    // screen coordinate in whole pixels, negative when a boss is partly off screen
    typedef logic signed [10:0] coordinate;

    // position or speed in 1/64 pixel units
    typedef logic signed [16:0] fixedPoint;

    typedef logic [1:0] objectId;    // boss index

    // hit flags, bit 3 left, bit 2 top, bit 1 right, bit 0 bottom
    typedef logic [3:0] edgeCode;

    typedef logic [15:0] lfsrState;

    // state of the position report sequencer
    typedef enum logic {
        idle,    // waiting for the next frame start
        send     // streaming snapshot beats out
    } reporterState;

    localparam int numObjects = 4;          // bosses on screen at the same time

    // fixed point scaling, a shift of 6 means a multiplier of 64
    localparam int fixedPointShift = 6;

    localparam int screenWidth  = 640;      // visible area in pixels
    localparam int screenHeight = 480;

    // side of the square hit box in pixels
    localparam int objectSize = 32;

    // fibonacci lfsr, taps at 16, 14, 13 and 11 map to bits 15, 13, 12 and 10
    localparam lfsrState lfsrSeed = 16'hACE1;
    localparam lfsrState lfsrTaps = 16'hB400;

    // bit numbers of the edge flags inside an edgeCode
    localparam int edgeLeft   = 3;
    localparam int edgeTop    = 2;
    localparam int edgeRight  = 1;
    localparam int edgeBottom = 0;

endpackage

//--- shotScheduler.sv
`timescale 1ns/10ps

module shotScheduler (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   startOfFrame,  // one cycle pulse at every frame start
    input  logic                   shotValid,
    input  bossMotionPkg::objectId shotTarget,    // boss that fires the shot
    output logic                   shotReady,
    output logic                   switchPulse [bossMotionPkg::numObjects],
    output logic                   randomAxis     // 1 reverses y, 0 reverses x
);

    import bossMotionPkg::*;

    lfsrState                lfsr;
    logic [numObjects-1:0]   pulseVec;   // the registered pulses as one packed vector
    logic                    shotAccept;

    // a shot is never taken on a move cycle so a reversal cannot land on one
    assign shotReady  = !startOfFrame;
    assign shotAccept = shotValid && shotReady;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            lfsr       <= lfsrSeed;
            pulseVec   <= '0;
            randomAxis <= 1'b0;
        end else begin
            pulseVec <= '0;                                 // pulses last a single cycle
            if (shotAccept) begin
                pulseVec[shotTarget] <= 1'b1;
                randomAxis           <= lfsr[0];            // axis comes from the state before the step
                lfsr                 <= {lfsr[14:0], ^(lfsr & lfsrTaps)};
            end
        end
    end

    // fan the packed pulses out to the per boss strobes
    always_comb begin
        for (int i = 0; i < numObjects; i++) begin
            switchPulse[i] = pulseVec[i];
        end
    end

    // never more than one boss reverses on the same cycle
    assert property (@(posedge clk) disable iff (!resetN) $onehot0(pulseVec))
        else $error("shotScheduler: more than one switch pulse at once");

endmodule

//--- bossMove.sv
`timescale 1ns/10ps

module bossMove #(
    parameter bossMotionPkg::coordinate initialX = 300,
    parameter bossMotionPkg::coordinate initialY = 200,
    parameter bossMotionPkg::fixedPoint xSpeed   = 24,   // in 1/64 pixel per frame
    parameter bossMotionPkg::fixedPoint ySpeed   = 24
) (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     startOfFrame,
    input  logic                     borderCollision,
    input  bossMotionPkg::edgeCode   hitEdgeCode,
    input  logic                     switchDirectionPulse,  // one cycle pulse per shot
    input  logic                     randomAxis,
    output bossMotionPkg::coordinate topLeftX,              // may go negative near the edges
    output bossMotionPkg::coordinate topLeftY
);

    import bossMotionPkg::*;

    fixedPoint posXFixed, posYFixed;    // position kept at 64 times the pixel resolution
    fixedPoint speedX, speedY;          // signed, sign gives the direction
    logic      bounceX, bounceY;
    logic      shotFlipX, shotFlipY;

    // bounce only when the boss is still heading into the wall it touches
    assign bounceX = borderCollision &&
        ((hitEdgeCode[edgeLeft] && speedX < 0) || (hitEdgeCode[edgeRight] && speedX > 0));
    assign bounceY = borderCollision &&
        ((hitEdgeCode[edgeTop] && speedY < 0) || (hitEdgeCode[edgeBottom] && speedY > 0));

    assign shotFlipX = switchDirectionPulse && !randomAxis;
    assign shotFlipY = switchDirectionPulse && randomAxis;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            speedX    <= xSpeed;
            speedY    <= ySpeed;
            posXFixed <= fixedPoint'(initialX) <<< fixedPointShift;
            posYFixed <= fixedPoint'(initialY) <<< fixedPointShift;
        end else begin
            // a bounce and a shot on the same axis cancel out
            if (bounceX ^ shotFlipX) begin
                speedX <= -speedX;
            end
            if (bounceY ^ shotFlipY) begin
                speedY <= -speedY;
            end
            if (startOfFrame) begin
                posXFixed <= posXFixed + speedX;   // one speed step per frame
                posYFixed <= posYFixed + speedY;
            end
        end
    end

    // arithmetic shift rounds toward minus infinity so a tiny overshoot reads as -1
    assign topLeftX = coordinate'(posXFixed >>> fixedPointShift);
    assign topLeftY = coordinate'(posYFixed >>> fixedPointShift);

    // reversals may flip the sign but the magnitude stays at the parameter value
    assert property (@(posedge clk) disable iff (!resetN)
        (speedX == xSpeed || speedX == -xSpeed) && (speedY == ySpeed || speedY == -ySpeed))
        else $error("bossMove: speed magnitude changed");

endmodule

//--- borderHitDetector.sv
`timescale 1ns/10ps

module borderHitDetector (
    input  bossMotionPkg::coordinate topLeftX        [bossMotionPkg::numObjects],
    input  bossMotionPkg::coordinate topLeftY        [bossMotionPkg::numObjects],
    output logic                     borderCollision [bossMotionPkg::numObjects],
    output bossMotionPkg::edgeCode   hitEdgeCode     [bossMotionPkg::numObjects]
);

    import bossMotionPkg::*;

    // right and bottom of each box, widened to int so the add cannot wrap
    int rightX  [numObjects];
    int bottomY [numObjects];

    always_comb begin
        for (int i = 0; i < numObjects; i++) begin
            rightX[i]  = int'(topLeftX[i]) + objectSize;
            bottomY[i] = int'(topLeftY[i]) + objectSize;
        end
    end

    // every boss is checked in parallel against the four screen limits
    always_comb begin
        for (int i = 0; i < numObjects; i++) begin
            hitEdgeCode[i] = '0;

            // left and top trip as soon as the corner leaves the screen
            hitEdgeCode[i][edgeLeft] = topLeftX[i] < 0;
            hitEdgeCode[i][edgeTop]  = topLeftY[i] < 0;

            // right and bottom use the far side of the hit box
            hitEdgeCode[i][edgeRight]  = rightX[i] > screenWidth;
            hitEdgeCode[i][edgeBottom] = bottomY[i] > screenHeight;

            borderCollision[i] = |hitEdgeCode[i];    // any edge counts as a hit
        end
    end

endmodule

//--- positionReporter.sv
`timescale 1ns/10ps

module positionReporter (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     startOfFrame,
    input  bossMotionPkg::coordinate topLeftX [bossMotionPkg::numObjects],
    input  bossMotionPkg::coordinate topLeftY [bossMotionPkg::numObjects],
    input  logic                     posReady,
    output logic                     posValid,
    output bossMotionPkg::objectId   posId,
    output bossMotionPkg::coordinate posX,
    output bossMotionPkg::coordinate posY,
    output logic                     frameDropped   // one cycle pulse when a frame was skipped
);

    import bossMotionPkg::*;

    reporterState state;
    objectId      sendIdx;                  // boss whose beat is on the output
    coordinate    snapX [numObjects];       // positions frozen at frame start
    coordinate    snapY [numObjects];
    logic         lastBeat;

    assign lastBeat = posReady && (sendIdx == objectId'(numObjects - 1));

    // control path
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state        <= idle;
            sendIdx      <= '0;
            frameDropped <= 1'b0;
        end else begin
            frameDropped <= 1'b0;
            case (state)
                idle: begin
                    if (startOfFrame) begin
                        state   <= send;
                        sendIdx <= '0;           // report always starts with boss 0
                    end
                end
                send: begin
                    // still busy with the last frame, so this one is lost
                    frameDropped <= startOfFrame;
                    if (lastBeat) begin
                        state <= idle;
                    end else if (posReady) begin
                        sendIdx <= sendIdx + objectId'(1);
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // snapshot holds the values before this frame's move lands
    always_ff @(posedge clk) begin
        if (state == idle && startOfFrame) begin
            snapX <= topLeftX;
            snapY <= topLeftY;
        end
    end

    assign posValid = (state == send);
    assign posId    = sendIdx;
    assign posX     = snapX[sendIdx];
    assign posY     = snapY[sendIdx];

    // a stalled beat must not change under the consumer
    assert property (@(posedge clk) disable iff (!resetN)
        posValid && !posReady |=> posValid && $stable(posId) && $stable(posX) && $stable(posY))
        else $error("positionReporter: output changed while stalled");

endmodule

//--- bossMotionTop.sv
`timescale 1ns/10ps

module bossMotionTop (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     startOfFrame,
    input  logic                     shotValid,
    output logic                     shotReady,
    input  bossMotionPkg::objectId   shotTarget,
    output logic                     posValid,
    input  logic                     posReady,
    output bossMotionPkg::objectId   posId,
    output bossMotionPkg::coordinate posX,
    output bossMotionPkg::coordinate posY,
    output logic                     frameDropped
);

    import bossMotionPkg::*;

    logic      switchPulse     [numObjects];
    logic      randomAxis;                      // shared, only the pulsed boss looks at it
    coordinate topLeftX        [numObjects];
    coordinate topLeftY        [numObjects];
    logic      borderCollision [numObjects];
    edgeCode   hitEdgeCode     [numObjects];

    shotScheduler shotSchedulerInst (
        .clk, .resetN, .startOfFrame,
        .shotValid, .shotTarget, .shotReady,
        .switchPulse, .randomAxis
    );

    // bosses spread over the screen, each with its own speed
    for (genvar i = 0; i < numObjects; i++) begin : bossGen
        bossMove #(
            .initialX (coordinate'(100 + 120 * i)),
            .initialY (coordinate'(80 + 90 * i)),
            .xSpeed   (fixedPoint'(24 + 8 * i)),
            .ySpeed   (fixedPoint'(40 - 8 * i))
        ) bossInst (
            .clk, .resetN, .startOfFrame,
            .borderCollision      (borderCollision[i]),
            .hitEdgeCode          (hitEdgeCode[i]),
            .switchDirectionPulse (switchPulse[i]),
            .randomAxis,
            .topLeftX             (topLeftX[i]),
            .topLeftY             (topLeftY[i])
        );
    end

    borderHitDetector borderHitDetectorInst (.topLeftX, .topLeftY, .borderCollision, .hitEdgeCode);

    positionReporter positionReporterInst (
        .clk, .resetN, .startOfFrame, .topLeftX, .topLeftY,
        .posReady, .posValid, .posId, .posX, .posY, .frameDropped
    );

endmodule

//--- bossMotionTb.sv
`timescale 1ns/10ps

module bossMotionTb;

    import bossMotionPkg::*;

    logic      clk;
    logic      resetN;
    logic      startOfFrame;
    logic      shotValid;
    logic      shotReady;
    objectId   shotTarget;
    logic      posValid;
    logic      posReady;
    objectId   posId;
    coordinate posX;
    coordinate posY;
    logic      frameDropped;

    // the reference model keeps positions and speeds in 1/64 pixel like the bosses
    int        modelPosX   [numObjects];
    int        modelPosY   [numObjects];
    int        modelSpeedX [numObjects];
    int        modelSpeedY [numObjects];
    lfsrState  modelLfsr;

    string     testName;
    int        readyMode;        // 0 always ready, 1 random stalls, 2 held low
    logic      reportBusy;       // reporter should be streaming beats this cycle
    int        mismatchCount;
    int        otherErrors;
    int        framesCaptured;
    int        framesDropped;    // frameDropped pulses seen on the DUT output
    int        beatsSeen;        // handshakes the DUT completed on the position port

    bossMotionTop UUT (
        .clk, .resetN, .startOfFrame, .shotValid, .shotReady, .shotTarget,
        .posValid, .posReady, .posId, .posX, .posY, .frameDropped
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic coordinate pixelOf(int posFixed);
        return coordinate'(posFixed >>> fixedPointShift);    // the floor makes -1/64 read as -1
    endfunction

    // speed after the border rule where limit is the screen size along that axis
    function automatic int reflectSpeed(int posFixed, int speed, int limit);
        int pixel;
        pixel = posFixed >>> fixedPointShift;
        if ((pixel < 0 && speed < 0) || (pixel + objectSize > limit && speed > 0)) begin
            return -speed;
        end
        return speed;
    endfunction

    task automatic bounceBoss(int i);
        modelSpeedX[i] = reflectSpeed(modelPosX[i], modelSpeedX[i], screenWidth);
        modelSpeedY[i] = reflectSpeed(modelPosY[i], modelSpeedY[i], screenHeight);
    endtask

    task automatic resetModel();
        for (int i = 0; i < numObjects; i++) begin
            modelPosX[i]   = (100 + 120 * i) << fixedPointShift;
            modelPosY[i]   = (80 + 90 * i) << fixedPointShift;
            modelSpeedX[i] = 24 + 8 * i;
            modelSpeedY[i] = 40 - 8 * i;
        end
        modelLfsr = lfsrSeed;
    endtask

    task automatic moveModel();
        for (int i = 0; i < numObjects; i++) begin
            modelPosX[i] += modelSpeedX[i];
            modelPosY[i] += modelSpeedY[i];
            bounceBoss(i);                    // the wall check follows one cycle after the move
        end
    endtask

    // axis is bit 0 before the step, 1 reverses y and 0 reverses x
    task automatic applyShot(objectId target);
        logic axis;
        axis = modelLfsr[0];
        modelLfsr = {modelLfsr[14:0],
                     modelLfsr[15] ^ modelLfsr[13] ^ modelLfsr[12] ^ modelLfsr[10]};
        if (axis) begin
            modelSpeedY[target] = -modelSpeedY[target];
        end else begin
            modelSpeedX[target] = -modelSpeedX[target];
        end
        bounceBoss(int'(target));             // a shot that turns a boss back into a wall bounces again
    endtask

    task automatic coordCompare(string label, coordinate expected, coordinate actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %0d, actual %0d", testName, label, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic idCompare(string label, objectId expected, objectId actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %0d, actual %0d", testName, label, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic bitCompare(string label, logic expected, logic actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %0b, actual %0b", testName, label, expected, actual);
            mismatchCount++;
        end
    endtask

    // called right after a falling edge and returns one falling edge after the handshake
    task automatic sendShot(objectId target);
        int waitCount;
        waitCount  = 0;
        shotValid  = 1'b1;
        shotTarget = target;
        #1;
        while (!shotReady && waitCount < 20) begin
            @(negedge clk);
            #1;
            waitCount++;
        end
        if (shotReady) begin
            applyShot(target);
        end else begin
            $display("error in %s: shot to boss %0d was never accepted", testName, target);
            otherErrors++;
        end
        @(negedge clk);
        shotValid = 1'b0;
    endtask

    // one frame is 10 cycles, move pulse first and then the shots in the middle
    task automatic runFrame(int numShots);
        objectId firstTarget;
        firstTarget  = objectId'($urandom % numObjects);
        startOfFrame = 1'b1;
        @(negedge clk);
        startOfFrame = 1'b0;
        moveModel();
        @(negedge clk);
        for (int k = 0; k < numShots; k++) begin
            sendShot(firstTarget + objectId'(k));    // never the same boss twice per frame
        end
        repeat (8 - numShots) @(negedge clk);
    endtask

    initial begin : readyDriver
        posReady = 1'b0;
        forever begin
            @(negedge clk);
            case (readyMode)
                0:       posReady = 1'b1;
                1:       posReady = ($urandom % 3) != 0;
                default: posReady = 1'b0;
            endcase
        end
    end

    // samples a nanosecond after the falling edge where every input has settled
    initial begin : compareOutputs
        coordinate expX [numObjects];
        coordinate expY [numObjects];
        int        beatIdx;
        logic      dropExpected;
        logic      captureNow;
        logic      dropNow;
        beatIdx      = 0;
        dropExpected = 1'b0;
        forever begin
            @(negedge clk);
            #1;
            if (resetN) begin
                bitCompare("posValid", reportBusy, posValid);
                bitCompare("frameDropped", dropExpected, frameDropped);
                bitCompare("shotReady", !startOfFrame, shotReady);
                captureNow = startOfFrame && !reportBusy;
                dropNow    = startOfFrame && reportBusy;    // busy at the frame edge loses that frame
                if (posValid === 1'b1 && posReady) begin
                    beatsSeen++;
                end
                if (frameDropped === 1'b1) begin
                    framesDropped++;
                end
                if (reportBusy) begin
                    idCompare("posId", objectId'(beatIdx), posId);
                    coordCompare("posX", expX[beatIdx], posX);
                    coordCompare("posY", expY[beatIdx], posY);
                    if (posReady) begin
                        beatIdx++;
                        reportBusy = (beatIdx < numObjects);
                    end
                end
                if (captureNow) begin
                    for (int i = 0; i < numObjects; i++) begin
                        expX[i] = pixelOf(modelPosX[i]);   // positions before this frame's move
                        expY[i] = pixelOf(modelPosY[i]);
                    end
                    beatIdx    = 0;
                    reportBusy = 1'b1;
                    framesCaptured++;
                end
                dropExpected = dropNow;
            end
        end
    end

    initial begin
        int dropsBefore;
        int waitCount;
        void'($urandom(68370));
        resetN         = 1'b0;
        startOfFrame   = 1'b0;
        shotValid      = 1'b0;
        shotTarget     = '0;
        readyMode      = 0;
        reportBusy     = 1'b0;
        mismatchCount  = 0;
        otherErrors    = 0;
        framesCaptured = 0;
        framesDropped  = 0;
        beatsSeen      = 0;
        testName       = "reset";
        resetModel();
        repeat (3) @(negedge clk);
        resetN = 1'b1;
        @(negedge clk);

        testName = "initialReport";
        runFrame(0);
        testName = "freeMotion";
        repeat (200) runFrame(0);
        testName = "randomShots";
        repeat (150) runFrame($urandom % 3);
        testName = "backPressure";
        readyMode = 1;
        repeat (150) runFrame($urandom % 3);

        // let the reporter drain, then stall it across whole frames
        testName = "droppedFrame";
        readyMode = 0;
        runFrame(0);
        dropsBefore = framesDropped;
        readyMode = 2;
        repeat (2) runFrame(0);
        readyMode = 0;
        repeat (2) runFrame(0);
        if (framesDropped == dropsBefore) begin
            $display("error in %s: no frame was dropped while posReady was held low", testName);
            otherErrors++;
        end

        waitCount = 0;
        while ((reportBusy || posValid) && waitCount < 50) begin
            @(negedge clk);
            waitCount++;
        end
        if (reportBusy || posValid) begin
            $display("error: the last position report never finished");
            otherErrors++;
        end
        if (beatsSeen != framesCaptured * numObjects) begin
            $display("error: %0d beats for %0d reported frames", beatsSeen, framesCaptured);
            otherErrors++;
        end

        $display("errors %0d, mismatches %0d, other failures %0d, frames %0d, dropped %0d",
                 mismatchCount + otherErrors, mismatchCount, otherErrors,
                 framesCaptured, framesDropped);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- bossMotion.f
bossMotionPkg.sv
shotScheduler.sv
bossMove.sv
borderHitDetector.sv
positionReporter.sv
bossMotionTop.sv
bossMotionTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, the output is kept in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module bossMotionTb -f bossMotion.f -o bossMotionSim \
    && ./obj_dir/bossMotionSim > sim.log 2>&1 \
    || echo "build or run ended with an error" >> sim.log

cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
